// File: Makefile
# Verilator flow for the butterfly crossbar testbench

TOP := bflyXbarTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f --Mdir obj_dir -o Vsim
	./obj_dir/Vsim

clean:
	rm -rf obj_dir

// File: bflyNet.sv
`timescale 1ns/1ps
/*
 * Two-stage 4x4 Radix-2 butterfly
 * Stage 0 routes on route bit 1, stage 1 on route bit 0, so every source
 * reaches every destination by exactly one path.
 */
module bflyNet #(
  // Bit s places spill registers on the outputs of stage s
  parameter logic [1:0] Spill = 2'b00
) (
  input  logic                                     clk_i,
  input  logic                                     rstN_i,
  // Source side
  input  logic [bflyPkg::NumPorts-1:0]              inValid_i,
  output logic [bflyPkg::NumPorts-1:0]              inReady_o,
  input  bflyPkg::netFlit_t [bflyPkg::NumPorts-1:0] inFlit_i,
  // Destination side
  output logic [bflyPkg::NumPorts-1:0]              outValid_o,
  input  logic [bflyPkg::NumPorts-1:0]              outReady_i,
  output bflyPkg::netFlit_t [bflyPkg::NumPorts-1:0] outFlit_o
);

  // Stage 0 outputs, indexed [switch][output]
  logic [1:0]              s0Valid [2];
  logic [1:0]              s0Ready [2];
  bflyPkg::netFlit_t [1:0] s0Flit [2];

  // Stage 1 inputs, indexed [switch][input]
  logic [1:0]              s1Valid [2];
  logic [1:0]              s1Ready [2];
  bflyPkg::netFlit_t [1:0] s1Flit [2];

  // Switch s serves ports 2s and 2s+1
  for (genvar s = 0; s < 2; s++) begin : genStage0
    bflySwitch #(
      .RouteBit(1),
      .Spill   (Spill[0])
    ) iSwitch (
      .clk_i     (clk_i),
      .rstN_i    (rstN_i),
      .inValid_i (inValid_i[2*s +: 2]),
      .inReady_o (inReady_o[2*s +: 2]),
      .inFlit_i  (inFlit_i[2*s +: 2]),
      .outValid_o(s0Valid[s]),
      .outReady_i(s0Ready[s]),
      .outFlit_o (s0Flit[s])
    );
  end

  // Shuffle: output o of stage 0 switch s feeds input s of stage 1 switch o
  for (genvar s = 0; s < 2; s++) begin : genShuffleSrc
    for (genvar o = 0; o < 2; o++) begin : genShuffleDst
      assign s1Valid[o][s] = s0Valid[s][o];
      assign s1Flit[o][s]  = s0Flit[s][o];
      assign s0Ready[s][o] = s1Ready[o][s];
    end
  end

  // Output p of switch o is network port 2o+p
  for (genvar o = 0; o < 2; o++) begin : genStage1
    bflySwitch #(
      .RouteBit(0),
      .Spill   (Spill[1])
    ) iSwitch (
      .clk_i     (clk_i),
      .rstN_i    (rstN_i),
      .inValid_i (s1Valid[o]),
      .inReady_o (s1Ready[o]),
      .inFlit_i  (s1Flit[o]),
      .outValid_o(outValid_o[2*o +: 2]),
      .outReady_i(outReady_i[2*o +: 2]),
      .outFlit_o (outFlit_o[2*o +: 2])
    );
  end

endmodule

// File: bflyPkg.sv
/*
 * Butterfly interconnect package
 * Port count, payload width and the flit and arbiter types shared by the
 * switchbox, the network and the crossbar top level.
 */
package bflyPkg;

  // Initiators and targets, one of each per port
  localparam int unsigned NumPorts = 4;

  // Width of an initiator or target index
  localparam int unsigned PortBits = $clog2(NumPorts);

  // Request write data and response read data
  localparam int unsigned DataWidth = 32;

  typedef logic [PortBits-1:0] portId_t;

  typedef logic [DataWidth-1:0] data_t;

  // Flit carried by both networks
  // route is the target index on requests, the initiator index on responses
  // src is the sender, used to return the response or report its origin
  typedef struct packed {
    portId_t route;
    portId_t src;
    data_t   data;
  } netFlit_t;

  // Round-robin state of a 2-input arbiter, naming the input that wins a tie
  typedef enum logic {
    PrioIn0 = 1'b0,
    PrioIn1 = 1'b1
  } rrPrio_e;

endpackage

// File: bflySwitch.sv
`timescale 1ns/1ps
/*
 * Butterfly 2x2 switchbox
 * Each input picks an output by one bit of its route field. Every output has
 * its own round-robin arbiter and can be buffered by a one-entry spill register.
 */
module bflySwitch #(
  parameter int unsigned RouteBit = 0,
  parameter bit          Spill    = 1'b0
) (
  input  logic                    clk_i,
  input  logic                    rstN_i,
  // Input side
  input  logic [1:0]              inValid_i,
  output logic [1:0]              inReady_o,
  input  bflyPkg::netFlit_t [1:0] inFlit_i,
  // Output side
  output logic [1:0]              outValid_o,
  input  logic [1:0]              outReady_i,
  output bflyPkg::netFlit_t [1:0] outFlit_o
);

  // Output requested by each input
  logic [1:0] outSel;
  // One-hot grant of each output, indexed [output][input]
  logic [1:0] gnt [2];
  // Ready seen by the arbiter of each output
  logic [1:0] arbReady;

  assign outSel[0] = inFlit_i[0].route[RouteBit];
  assign outSel[1] = inFlit_i[1].route[RouteBit];

  // An input only ever requests one output, so at most one term is set
  for (genvar k = 0; k < 2; k++) begin : genInReady
    assign inReady_o[k] = (gnt[0][k] & arbReady[0]) | (gnt[1][k] & arbReady[1]);
  end

  for (genvar o = 0; o < 2; o++) begin : genOut
    logic [1:0]        req;
    logic              contest;
    logic              arbValid;
    logic              gntIdx;
    bflyPkg::netFlit_t arbFlit;
    bflyPkg::rrPrio_e  prioQ;
    logic              lockQ;
    logic              lockIdxQ;

    assign req[0]   = inValid_i[0] & (outSel[0] == 1'(o));
    assign req[1]   = inValid_i[1] & (outSel[1] == 1'(o));
    assign contest  = &req;
    assign arbValid = |req;

    // A flit that was offered and not taken keeps its grant, so the
    // output flit stays stable while it waits
    always_comb begin
      if (lockQ) begin
        gntIdx = lockIdxQ;
      end else if (contest) begin
        gntIdx = (prioQ == bflyPkg::PrioIn1);
      end else begin
        gntIdx = req[1];
      end
    end

    assign gnt[o]  = arbValid ? (2'b01 << gntIdx) : 2'b00;
    assign arbFlit = inFlit_i[gntIdx];

    always_ff @(posedge clk_i or negedge rstN_i) begin
      if (!rstN_i) begin
        prioQ <= bflyPkg::PrioIn0;
        lockQ <= 1'b0;
      end else begin
        lockQ <= arbValid & ~arbReady[o];
        // Winner of a contest yields the next tie to the other input
        if (contest && arbReady[o]) begin
          prioQ <= gntIdx ? bflyPkg::PrioIn0 : bflyPkg::PrioIn1;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      lockIdxQ <= gntIdx;
    end

    if (Spill) begin : genSpill
      logic              fullQ;
      bflyPkg::netFlit_t dataQ;

      // Accept when empty or when the held flit leaves this cycle
      assign arbReady[o]   = ~fullQ | outReady_i[o];
      assign outValid_o[o] = fullQ;
      assign outFlit_o[o]  = dataQ;

      always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
          fullQ <= 1'b0;
        end else if (arbValid && arbReady[o]) begin
          fullQ <= 1'b1;
        end else if (outReady_i[o]) begin
          fullQ <= 1'b0;
        end
      end

      always_ff @(posedge clk_i) begin
        if (arbValid && arbReady[o]) begin
          dataQ <= arbFlit;
        end
      end
    end else begin : genBypass
      // Combinational path, no added latency
      assign arbReady[o]   = outReady_i[o];
      assign outValid_o[o] = arbValid;
      assign outFlit_o[o]  = arbFlit;
    end
  end

endmodule

// File: bflyXbar.sv
`timescale 1ns/1ps
/*
 * Full-duplex 4x4 butterfly crossbar
 * A request network carries initiator requests to the targets and a
 * response network returns each answer to the initiator that asked.
 */
module bflyXbar #(
  parameter logic [1:0] SpillReq  = 2'b01,
  parameter logic [1:0] SpillResp = 2'b10
) (
  input  logic                                    clk_i,
  input  logic                                    rstN_i,
  // Initiator side
  input  logic [bflyPkg::NumPorts-1:0]             reqValid_i,
  output logic [bflyPkg::NumPorts-1:0]             reqReady_o,
  input  bflyPkg::portId_t [bflyPkg::NumPorts-1:0] reqTgt_i,
  input  bflyPkg::data_t [bflyPkg::NumPorts-1:0]   reqWdata_i,
  output logic [bflyPkg::NumPorts-1:0]             respValid_o,
  input  logic [bflyPkg::NumPorts-1:0]             respReady_i,
  output bflyPkg::data_t [bflyPkg::NumPorts-1:0]   respRdata_o,
  output bflyPkg::portId_t [bflyPkg::NumPorts-1:0] respTgt_o,
  // Target side
  output logic [bflyPkg::NumPorts-1:0]             reqValid_o,
  input  logic [bflyPkg::NumPorts-1:0]             reqReady_i,
  output bflyPkg::portId_t [bflyPkg::NumPorts-1:0] reqIni_o,
  output bflyPkg::data_t [bflyPkg::NumPorts-1:0]   reqWdata_o,
  input  logic [bflyPkg::NumPorts-1:0]             respValid_i,
  output logic [bflyPkg::NumPorts-1:0]             respReady_o,
  input  bflyPkg::portId_t [bflyPkg::NumPorts-1:0] respIni_i,
  input  bflyPkg::data_t [bflyPkg::NumPorts-1:0]   respRdata_i
);

  bflyPkg::netFlit_t [bflyPkg::NumPorts-1:0] reqInFlit;
  bflyPkg::netFlit_t [bflyPkg::NumPorts-1:0] reqOutFlit;
  bflyPkg::netFlit_t [bflyPkg::NumPorts-1:0] respInFlit;
  bflyPkg::netFlit_t [bflyPkg::NumPorts-1:0] respOutFlit;

  for (genvar p = 0; p < bflyPkg::NumPorts; p++) begin : genPorts
    // Requests enter at initiator p, routed by target index
    assign reqInFlit[p].route = reqTgt_i[p];
    assign reqInFlit[p].src   = bflyPkg::portId_t'(p);
    assign reqInFlit[p].data  = reqWdata_i[p];

    // Source of a delivered request is the issuing initiator
    assign reqIni_o[p]   = reqOutFlit[p].src;
    assign reqWdata_o[p] = reqOutFlit[p].data;

    // Responses enter at target p, routed back by initiator index
    assign respInFlit[p].route = respIni_i[p];
    assign respInFlit[p].src   = bflyPkg::portId_t'(p);
    assign respInFlit[p].data  = respRdata_i[p];

    assign respRdata_o[p] = respOutFlit[p].data;
    assign respTgt_o[p]   = respOutFlit[p].src;
  end

  bflyNet #(
    .Spill(SpillReq)
  ) iReqNet (
    .clk_i     (clk_i),
    .rstN_i    (rstN_i),
    .inValid_i (reqValid_i),
    .inReady_o (reqReady_o),
    .inFlit_i  (reqInFlit),
    .outValid_o(reqValid_o),
    .outReady_i(reqReady_i),
    .outFlit_o (reqOutFlit)
  );

  bflyNet #(
    .Spill(SpillResp)
  ) iRespNet (
    .clk_i     (clk_i),
    .rstN_i    (rstN_i),
    .inValid_i (respValid_i),
    .inReady_o (respReady_o),
    .inFlit_i  (respInFlit),
    .outValid_o(respValid_o),
    .outReady_i(respReady_i),
    .outFlit_o (respOutFlit)
  );

endmodule

// File: bflyXbarTb.sv
`timescale 1ns/1ps
/*
 * Testbench for the 4x4 butterfly crossbar
 * Launches table rows from the initiators, answers them with behavioural
 * targets and checks routing, payload, latency and exactly-once delivery.
 */
module bflyXbarTb;

  localparam int NumPorts      = bflyPkg::NumPorts;
  localparam int NumRows       = 10;
  localparam int NumGroups     = 4;
  localparam int TimeoutCycles = 40 * NumRows + 100;

  // One request per row, rows of a group launch together
  typedef struct {
    int               group;
    bflyPkg::portId_t ini;
    bflyPkg::portId_t tgt;
    bflyPkg::data_t   wdata;
    bit               timed;
  } stimRow_t;

  logic clk;
  logic rstN;

  logic [NumPorts-1:0]                     iniReqValid;
  logic [NumPorts-1:0]                     iniReqReady;
  bflyPkg::portId_t [NumPorts-1:0]         iniReqTgt;
  bflyPkg::data_t [NumPorts-1:0]           iniReqWdata;
  logic [NumPorts-1:0]                     iniRespValid;
  logic [NumPorts-1:0]                     iniRespReady;
  bflyPkg::data_t [NumPorts-1:0]           iniRespRdata;
  bflyPkg::portId_t [NumPorts-1:0]         iniRespTgt;
  logic [NumPorts-1:0]                     tgtReqValid;
  logic [NumPorts-1:0]                     tgtReqReady;
  bflyPkg::portId_t [NumPorts-1:0]         tgtReqIni;
  bflyPkg::data_t [NumPorts-1:0]           tgtReqWdata;
  logic [NumPorts-1:0]                     tgtRespValid;
  logic [NumPorts-1:0]                     tgtRespReady;
  bflyPkg::portId_t [NumPorts-1:0]         tgtRespIni;
  bflyPkg::data_t [NumPorts-1:0]           tgtRespRdata;

  stimRow_t          stimTable [NumRows];
  bit                reqSeen [NumRows];
  bit                respSeen [NumRows];
  int                reqXferCycle [NumRows];
  int                respSendCycle [NumRows];
  bflyPkg::netFlit_t rspQueue [NumPorts][$];
  int                cycle;
  int                curGroup;
  int                respDone;
  bit                randReady;

  bflyXbar DUT (
    .clk_i      (clk),
    .rstN_i     (rstN),
    .reqValid_i (iniReqValid),
    .reqReady_o (iniReqReady),
    .reqTgt_i   (iniReqTgt),
    .reqWdata_i (iniReqWdata),
    .respValid_o(iniRespValid),
    .respReady_i(iniRespReady),
    .respRdata_o(iniRespRdata),
    .respTgt_o  (iniRespTgt),
    .reqValid_o (tgtReqValid),
    .reqReady_i (tgtReqReady),
    .reqIni_o   (tgtReqIni),
    .reqWdata_o (tgtReqWdata),
    .respValid_i(tgtRespValid),
    .respReady_o(tgtRespReady),
    .respIni_i  (tgtRespIni),
    .respRdata_i(tgtRespRdata)
  );

  task automatic endFailed();
    $display("Simulation FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic reportError(input string msg);
    $display("%s", msg);
    endFailed();
  endtask

  task automatic reportValueError(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    endFailed();
  endtask

  task automatic checkReq(input bflyPkg::portId_t gotTgt, input bflyPkg::portId_t expTgt,
                          input bflyPkg::portId_t ini, input bflyPkg::data_t gotData,
                          input bflyPkg::data_t expData);
    if (gotTgt !== expTgt || gotData !== expData) begin
      reportValueError($sformatf("request of initiator %0d at target %0d data %h, expected %0d %h",
                                 ini, gotTgt, gotData, expTgt, expData));
    end
  endtask

  task automatic checkResp(input bflyPkg::portId_t gotTgt, input bflyPkg::portId_t expTgt,
                           input bflyPkg::portId_t ini, input bflyPkg::data_t gotData,
                           input bflyPkg::data_t expData);
    if (gotTgt !== expTgt || gotData !== expData) begin
      reportValueError($sformatf("response at initiator %0d from target %0d data %h, expected %0d %h",
                                 ini, gotTgt, gotData, expTgt, expData));
    end
  endtask

  // Row of a group launched by one initiator, -1 if there is none
  function automatic int findRow(input int grp, input bflyPkg::portId_t ini);
    int idx;
    idx = -1;
    for (int r = 0; r < NumRows; r++) begin
      if (stimTable[r].group == grp && stimTable[r].ini == ini) begin
        idx = r;
      end
    end
    return idx;
  endfunction

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin : timeoutCounter
    cycle = 0;
    forever begin
      @(posedge clk);
      cycle <= cycle + 1;
      if (cycle >= TimeoutCycles) begin
        reportError($sformatf("Timeout after %0d cycles, a transfer never completed",
                              TimeoutCycles));
      end
    end
  end

  // Target ready and initiator response ready, random only under contention
  initial begin : readyGen
    logic [31:0] rnd;
    void'($urandom(32'hda63));
    tgtReqReady  = '1;
    iniRespReady = '1;
    forever begin
      @(posedge clk);
      if (randReady) begin
        rnd = $urandom;
        tgtReqReady  <= rnd[NumPorts-1:0];
        iniRespReady <= rnd[NumPorts+3:4];
      end else begin
        tgtReqReady  <= '1;
        iniRespReady <= '1;
      end
    end
  end

  // Behavioural targets answer each request with the inverted write data
  initial begin : targetModel
    int                r;
    bflyPkg::netFlit_t rsp;
    tgtRespValid = '0;
    tgtRespIni   = '0;
    tgtRespRdata = '0;
    forever begin
      @(posedge clk);
      for (int t = 0; t < NumPorts; t++) begin
        if (tgtRespValid[t] && tgtRespReady[t]) begin
          r = findRow(curGroup, tgtRespIni[t]);
          if (r >= 0) begin
            respSendCycle[r] = cycle;
          end
          tgtRespValid[t] <= 1'b0;
        end
        if (rstN && tgtReqValid[t] && tgtReqReady[t]) begin
          r = findRow(curGroup, tgtReqIni[t]);
          if (r < 0) begin
            reportError($sformatf("Target %0d got a request from idle initiator %0d",
                                  t, tgtReqIni[t]));
          end else if (reqSeen[r]) begin
            reportError($sformatf("Request of initiator %0d delivered twice", tgtReqIni[t]));
          end else begin
            checkReq(bflyPkg::portId_t'(t), stimTable[r].tgt, tgtReqIni[t], tgtReqWdata[t],
                     stimTable[r].wdata);
            if (stimTable[r].timed && cycle - reqXferCycle[r] != 1) begin
              reportValueError($sformatf("request latency %0d at target %0d, expected 1",
                                         cycle - reqXferCycle[r], t));
            end
            reqSeen[r] = 1'b1;
            rsp.route  = tgtReqIni[t];
            rsp.src    = bflyPkg::portId_t'(t);
            rsp.data   = ~tgtReqWdata[t];
            rspQueue[t].push_back(rsp);
          end
        end
        if ((!tgtRespValid[t] || tgtRespReady[t]) && rspQueue[t].size() > 0) begin
          rsp = rspQueue[t].pop_front();
          tgtRespValid[t] <= 1'b1;
          tgtRespIni[t]   <= rsp.route;
          tgtRespRdata[t] <= rsp.data;
        end
      end
    end
  end

  initial begin : respMonitor
    int r;
    int n;
    respDone = 0;
    forever begin
      @(posedge clk);
      n = 0;
      for (int i = 0; i < NumPorts; i++) begin
        if (rstN && iniRespValid[i] && iniRespReady[i]) begin
          r = findRow(curGroup, bflyPkg::portId_t'(i));
          if (r < 0) begin
            reportError($sformatf("Initiator %0d got a response it never asked for", i));
          end else if (respSeen[r] || !reqSeen[r]) begin
            reportError($sformatf("Initiator %0d got a duplicate or early response", i));
          end else begin
            checkResp(iniRespTgt[i], stimTable[r].tgt, bflyPkg::portId_t'(i), iniRespRdata[i],
                      ~stimTable[r].wdata);
            if (stimTable[r].timed && cycle - respSendCycle[r] != 1) begin
              reportValueError($sformatf("response latency %0d at initiator %0d, expected 1",
                                         cycle - respSendCycle[r], i));
            end
            respSeen[r] = 1'b1;
            n++;
          end
        end
      end
      respDone <= respDone + n;
    end
  end

  initial begin : mainSeq
    int launched;
    int r;
    stimTable = '{
      '{0, 2'd1, 2'd2, 32'h1234_5678, 1'b1},
      '{1, 2'd3, 2'd0, 32'hcafe_0001, 1'b1},
      // Permutation, no two requests share a switch output
      '{2, 2'd0, 2'd1, 32'h0000_00a0, 1'b1},
      '{2, 2'd1, 2'd3, 32'h0000_00a1, 1'b1},
      '{2, 2'd2, 2'd0, 32'h0000_00a2, 1'b1},
      '{2, 2'd3, 2'd2, 32'h0000_00a3, 1'b1},
      // All initiators to one target
      '{3, 2'd0, 2'd2, 32'h5a5a_0000, 1'b0},
      '{3, 2'd1, 2'd2, 32'h5a5a_0001, 1'b0},
      '{3, 2'd2, 2'd2, 32'h5a5a_0002, 1'b0},
      '{3, 2'd3, 2'd2, 32'h5a5a_0003, 1'b0}
    };
    rstN        = 1'b0;
    iniReqValid = '0;
    iniReqTgt   = '0;
    iniReqWdata = '0;
    curGroup    = 0;
    randReady   = 1'b0;
    launched    = 0;
    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    repeat (3) begin
      @(posedge clk);
      if (tgtReqValid != '0 || iniRespValid != '0) begin
        reportError("An output valid rose before any request was launched");
      end
    end
    for (int g = 0; g < NumGroups; g++) begin
      @(posedge clk);
      curGroup <= g;
      for (int k = 0; k < NumRows; k++) begin
        if (stimTable[k].group == g) begin
          iniReqValid[stimTable[k].ini] <= 1'b1;
          iniReqTgt[stimTable[k].ini]   <= stimTable[k].tgt;
          iniReqWdata[stimTable[k].ini] <= stimTable[k].wdata;
          randReady <= !stimTable[k].timed;
          launched++;
        end
      end
      // Drop each valid once taken, then wait for every response
      do begin
        @(posedge clk);
        for (int i = 0; i < NumPorts; i++) begin
          if (iniReqValid[i] && iniReqReady[i]) begin
            iniReqValid[i] <= 1'b0;
            r = findRow(g, bflyPkg::portId_t'(i));
            reqXferCycle[r] = cycle;
          end
        end
      end while (respDone < launched);
    end
    // Idle cycles so that a late duplicate still reaches the monitors
    repeat (10) @(posedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: bflyXbar_chk.sv
`timescale 1ns/1ps
/*
 * Handshake checker for the butterfly crossbar
 * Valids stay low in reset and a stalled valid keeps its payload.
 */
module bflyXbar_chk (
  input logic                                    clk_i,
  input logic                                    rstN_i,
  input logic [bflyPkg::NumPorts-1:0]             reqValid_i,
  input logic [bflyPkg::NumPorts-1:0]             reqReady_o,
  input bflyPkg::portId_t [bflyPkg::NumPorts-1:0] reqTgt_i,
  input bflyPkg::data_t [bflyPkg::NumPorts-1:0]   reqWdata_i,
  input logic [bflyPkg::NumPorts-1:0]             respValid_o,
  input logic [bflyPkg::NumPorts-1:0]             respReady_i,
  input bflyPkg::data_t [bflyPkg::NumPorts-1:0]   respRdata_o,
  input bflyPkg::portId_t [bflyPkg::NumPorts-1:0] respTgt_o,
  input logic [bflyPkg::NumPorts-1:0]             reqValid_o,
  input logic [bflyPkg::NumPorts-1:0]             reqReady_i,
  input bflyPkg::portId_t [bflyPkg::NumPorts-1:0] reqIni_o,
  input bflyPkg::data_t [bflyPkg::NumPorts-1:0]   reqWdata_o,
  input logic [bflyPkg::NumPorts-1:0]             respValid_i,
  input logic [bflyPkg::NumPorts-1:0]             respReady_o,
  input bflyPkg::portId_t [bflyPkg::NumPorts-1:0] respIni_i,
  input bflyPkg::data_t [bflyPkg::NumPorts-1:0]   respRdata_i
);

  assert property (@(posedge clk_i) !rstN_i |-> reqValid_i == '0 && respValid_o == '0
                   && reqValid_o == '0 && respValid_i == '0)
    else $error("valid high while reset is active");

  // A stalled valid holds with the same flit
  for (genvar p = 0; p < bflyPkg::NumPorts; p++) begin : genHold
    assert property (@(posedge clk_i) disable iff (!rstN_i)
      reqValid_i[p] && !reqReady_o[p] |=> reqValid_i[p] && $stable(reqTgt_i[p])
                                          && $stable(reqWdata_i[p]))
      else $error("initiator %0d request changed while stalled", p);
    assert property (@(posedge clk_i) disable iff (!rstN_i)
      respValid_o[p] && !respReady_i[p] |=> respValid_o[p] && $stable(respTgt_o[p])
                                            && $stable(respRdata_o[p]))
      else $error("initiator %0d response changed while stalled", p);
    assert property (@(posedge clk_i) disable iff (!rstN_i)
      reqValid_o[p] && !reqReady_i[p] |=> reqValid_o[p] && $stable(reqIni_o[p])
                                          && $stable(reqWdata_o[p]))
      else $error("target %0d request changed while stalled", p);
    assert property (@(posedge clk_i) disable iff (!rstN_i)
      respValid_i[p] && !respReady_o[p] |=> respValid_i[p] && $stable(respIni_i[p])
                                            && $stable(respRdata_i[p]))
      else $error("target %0d response changed while stalled", p);
  end

endmodule

bind bflyXbar bflyXbar_chk iChk (
  .clk_i      (clk_i),
  .rstN_i     (rstN_i),
  .reqValid_i (reqValid_i),
  .reqReady_o (reqReady_o),
  .reqTgt_i   (reqTgt_i),
  .reqWdata_i (reqWdata_i),
  .respValid_o(respValid_o),
  .respReady_i(respReady_i),
  .respRdata_o(respRdata_o),
  .respTgt_o  (respTgt_o),
  .reqValid_o (reqValid_o),
  .reqReady_i (reqReady_i),
  .reqIni_o   (reqIni_o),
  .reqWdata_o (reqWdata_o),
  .respValid_i(respValid_i),
  .respReady_o(respReady_o),
  .respIni_i  (respIni_i),
  .respRdata_i(respRdata_i)
);

// File: sim.f
bflyPkg.sv
bflySwitch.sv
bflyNet.sv
bflyXbar.sv
bflyXbar_chk.sv
bflyXbarTb.sv
